// File: build.f
+incdir+design
design/cpu_pkg.sv
design/instr_decoder.sv
design/scoreboard.sv
design/register_file.sv
design/alu_unit.sv
design/mem_unit.sv
design/scoreboard_cpu.sv
test/tb_scoreboard_cpu.sv

// File: design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module alu_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  cpu_pkg::fu_op_t    op,
	input  cpu_pkg::reg_addr_t dest,
	input  cpu_pkg::word_t     operand_a,
	input  cpu_pkg::word_t     operand_b,
	input  logic               grant,
	output logic               done,
	output cpu_pkg::reg_addr_t res_dest,
	output cpu_pkg::word_t     result
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else if (start) begin
			done <= 1'b1;
		end else if (done && (grant || res_dest == `CPU_NO_DEST)) begin
			done <= 1'b0;
		end
	end

	// result held until writeback
	always_ff @(posedge clk) begin
		if (start) begin
			res_dest <= dest;
			result <= (op == cpu_pkg::OP_SUB) ? operand_a - operand_b : operand_a + operand_b;
		end
	end

endmodule

`default_nettype wire

// File: design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////
`define CPU_DATA_WIDTH 16
`define CPU_REG_COUNT 8

// register 7 doubles as the no-write code
`define CPU_NO_DEST 3'd7

// data RAM
`define CPU_MEM_DEPTH 32
`define CPU_MEM_LATENCY 4

//////////////////////////////
// opcodes, instr[15:11]
//////////////////////////////
`define CPU_OPC_ADD_IMM 5'b00000
`define CPU_OPC_ADD_REG 5'b00001
`define CPU_OPC_SUB_IMM 5'b00010
`define CPU_OPC_SUB_REG 5'b00011
`define CPU_OPC_LD 5'b10100
`define CPU_OPC_ST 5'b10110

`endif

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

	// one data word
	typedef logic [`CPU_DATA_WIDTH-1:0] word_t;

	// register number
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_addr_t;

	// operation carried to a functional unit
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_LOAD,
		OP_STORE,
		OP_NOP
	} fu_op_t;

	// functional unit id, FU_NONE when no unit produces a register
	typedef enum logic [1:0] {
		FU_ALU0,
		FU_ALU1,
		FU_MEM,
		FU_NONE
	} fu_id_t;

endpackage

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module instr_decoder (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  cpu_pkg::word_t     instr,
	input  logic               issue,
	output logic               stall,
	output logic               dec_valid,
	output cpu_pkg::fu_op_t    dec_op,
	output cpu_pkg::reg_addr_t dec_dest,
	output cpu_pkg::reg_addr_t dec_src0,
	output cpu_pkg::reg_addr_t dec_src1,
	output logic               dec_use_imm,
	output cpu_pkg::word_t     dec_imm
);

	cpu_pkg::fu_op_t    op_next;
	cpu_pkg::reg_addr_t dest_next;
	cpu_pkg::reg_addr_t src1_next;
	logic               use_imm_next;
	logic               take;

	always_comb begin
		op_next = cpu_pkg::OP_NOP;
		dest_next = instr[10:8];
		src1_next = instr[2:0];
		use_imm_next = 1'b0;
		case (instr[15:11])
			`CPU_OPC_ADD_IMM: begin
				op_next = cpu_pkg::OP_ADD;
				use_imm_next = 1'b1;
			end
			`CPU_OPC_ADD_REG: op_next = cpu_pkg::OP_ADD;
			`CPU_OPC_SUB_IMM: begin
				op_next = cpu_pkg::OP_SUB;
				use_imm_next = 1'b1;
			end
			`CPU_OPC_SUB_REG: op_next = cpu_pkg::OP_SUB;
			`CPU_OPC_LD: begin
				op_next = cpu_pkg::OP_LOAD;
				use_imm_next = 1'b1;
			end
			`CPU_OPC_ST: begin
				// dest field names the data register, nothing is written
				op_next = cpu_pkg::OP_STORE;
				src1_next = instr[10:8];
				dest_next = `CPU_NO_DEST;
			end
			default: dest_next = `CPU_NO_DEST;
		endcase
	end

	// holding register full and not leaving this cycle
	assign stall = dec_valid && !issue;
	assign take = instr_valid && !stall;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (take) begin
			// unknown opcodes never enter the holding register
			dec_valid <= (op_next != cpu_pkg::OP_NOP);
		end else if (issue) begin
			dec_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			dec_op <= op_next;
			dec_dest <= dest_next;
			dec_src0 <= instr[7:5];
			dec_src1 <= src1_next;
			dec_use_imm <= use_imm_next;
			dec_imm <= {{(`CPU_DATA_WIDTH - 5){instr[4]}}, instr[4:0]};
		end
	end

endmodule

`default_nettype wire

// File: design/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module mem_unit #(
	parameter int LATENCY = `CPU_MEM_LATENCY
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  cpu_pkg::fu_op_t    op,
	input  cpu_pkg::reg_addr_t dest,
	input  cpu_pkg::word_t     operand_a,
	input  cpu_pkg::word_t     operand_b,
	input  logic               grant,
	output logic               done,
	output cpu_pkg::reg_addr_t res_dest,
	output cpu_pkg::word_t     result
);

	localparam int ADDR_W = $clog2(`CPU_MEM_DEPTH);
	localparam int CNT_W = $clog2(LATENCY + 1);

	cpu_pkg::word_t    ram [0:`CPU_MEM_DEPTH-1];
	logic [ADDR_W-1:0] addr;
	logic [ADDR_W-1:0] addr_q;
	logic [CNT_W-1:0]  cnt;
	logic              is_load_q;
	logic              finish;

	// a store brings its offset already added into operand_a
	assign addr = (op == cpu_pkg::OP_STORE) ? operand_a[ADDR_W-1:0]
		: operand_a[ADDR_W-1:0] + operand_b[ADDR_W-1:0];
	assign finish = (cnt == CNT_W'(1));

	//////////////////////////////
	// latency counter
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			done <= 1'b0;
		end else begin
			if (start) begin
				cnt <= CNT_W'(LATENCY - 1);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
			if (finish) begin
				done <= 1'b1;
			end else if (done && (grant || res_dest == `CPU_NO_DEST)) begin
				done <= 1'b0;
			end
		end
	end

	// data RAM and held load result
	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= addr;
			is_load_q <= (op == cpu_pkg::OP_LOAD);
			res_dest <= (op == cpu_pkg::OP_STORE) ? `CPU_NO_DEST : dest;
			if (op == cpu_pkg::OP_STORE) begin
				ram[addr] <= operand_b;
			end
		end
		if (finish && is_load_q) begin
			result <= ram[addr_q];
		end
	end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module register_file (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::reg_addr_t rd_addr [0:3],
	output cpu_pkg::word_t     rd_data [0:3],
	input  logic               wb_valid,
	input  cpu_pkg::reg_addr_t wb_dest,
	input  cpu_pkg::word_t     wb_value
);

	cpu_pkg::word_t regs [0:`CPU_REG_COUNT-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int r = 0; r < `CPU_REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb_dest] <= wb_value;
		end
	end

	// write-through to same-cycle readers
	always_comb begin
		for (int p = 0; p < 4; p++) begin
			if (wb_valid && wb_dest == rd_addr[p]) begin
				rd_data[p] = wb_value;
			end else begin
				rd_data[p] = regs[rd_addr[p]];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module scoreboard (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               dec_valid,
	input  cpu_pkg::fu_op_t    dec_op,
	input  cpu_pkg::reg_addr_t dec_dest,
	input  cpu_pkg::reg_addr_t dec_src0,
	input  cpu_pkg::reg_addr_t dec_src1,
	input  logic               dec_use_imm,
	input  cpu_pkg::word_t     dec_imm,
	output logic               issue,
	output cpu_pkg::reg_addr_t rd_addr [0:3],
	input  cpu_pkg::word_t     rd_data [0:3],
	output logic               start_alu0,
	output cpu_pkg::fu_op_t    op_alu0,
	output cpu_pkg::reg_addr_t dest_alu0,
	output cpu_pkg::word_t     operand_a_alu0,
	output cpu_pkg::word_t     operand_b_alu0,
	input  logic               done_alu0,
	input  cpu_pkg::reg_addr_t res_dest_alu0,
	input  cpu_pkg::word_t     result_alu0,
	output logic               grant_alu0,
	output logic               start_alu1,
	output cpu_pkg::fu_op_t    op_alu1,
	output cpu_pkg::reg_addr_t dest_alu1,
	output cpu_pkg::word_t     operand_a_alu1,
	output cpu_pkg::word_t     operand_b_alu1,
	input  logic               done_alu1,
	input  cpu_pkg::reg_addr_t res_dest_alu1,
	input  cpu_pkg::word_t     result_alu1,
	output logic               grant_alu1,
	output logic               start_mem,
	output cpu_pkg::fu_op_t    op_mem,
	output cpu_pkg::reg_addr_t dest_mem,
	output cpu_pkg::word_t     operand_a_mem,
	output cpu_pkg::word_t     operand_b_mem,
	input  logic               done_mem,
	input  cpu_pkg::reg_addr_t res_dest_mem,
	input  cpu_pkg::word_t     result_mem,
	output logic               grant_mem,
	output logic               wb_valid,
	output cpu_pkg::reg_addr_t wb_dest,
	output cpu_pkg::word_t     wb_value
);

	localparam int UNITS = 3;

	// unit status, index 0 alu0, 1 alu1, 2 mem
	logic [UNITS-1:0]   busy;
	logic [UNITS-1:0]   waiting;
	logic [UNITS-1:0]   r0;
	logic [UNITS-1:0]   r1;
	logic [UNITS-1:0]   use_imm_q;
	cpu_pkg::fu_op_t    op_q [0:UNITS-1];
	cpu_pkg::reg_addr_t dest_q [0:UNITS-1];
	cpu_pkg::reg_addr_t src0_q [0:UNITS-1];
	cpu_pkg::reg_addr_t src1_q [0:UNITS-1];
	cpu_pkg::fu_id_t    q0 [0:UNITS-1];
	cpu_pkg::fu_id_t    q1 [0:UNITS-1];
	cpu_pkg::word_t     imm_q [0:UNITS-1];
	// register status, producing unit per register
	cpu_pkg::fu_id_t    reg_unit [0:`CPU_REG_COUNT-1];

	logic [UNITS-1:0]   done;
	logic [UNITS-1:0]   ready;
	logic [UNITS-1:0]   start;
	logic [UNITS-1:0]   cand;
	logic [UNITS-1:0]   grant;
	logic [UNITS-1:0]   free;
	cpu_pkg::reg_addr_t res_dest [0:UNITS-1];
	cpu_pkg::word_t     result [0:UNITS-1];
	cpu_pkg::fu_id_t    sel;
	cpu_pkg::fu_id_t    gnt_unit;
	logic               dest_clear;

	assign done = {done_mem, done_alu1, done_alu0};
	assign res_dest[0] = res_dest_alu0;
	assign res_dest[1] = res_dest_alu1;
	assign res_dest[2] = res_dest_mem;
	assign result[0] = result_alu0;
	assign result[1] = result_alu1;
	assign result[2] = result_mem;

	// a source produced by the unit writing back now counts as ready
	function automatic logic src_ready(input cpu_pkg::fu_id_t q);
		return (q == cpu_pkg::FU_NONE) || (wb_valid && q == gnt_unit);
	endfunction

	//////////////////////////////
	// issue
	//////////////////////////////
	always_comb begin
		sel = cpu_pkg::FU_NONE;
		if (dec_op == cpu_pkg::OP_LOAD || dec_op == cpu_pkg::OP_STORE) begin
			if (!busy[2]) begin
				sel = cpu_pkg::FU_MEM;
			end
		end else if (!busy[0]) begin
			sel = cpu_pkg::FU_ALU0;
		end else if (!busy[1]) begin
			sel = cpu_pkg::FU_ALU1;
		end
	end

	// WAW check
	assign dest_clear = (dec_dest == `CPU_NO_DEST) || (reg_unit[dec_dest] == cpu_pkg::FU_NONE);
	assign issue = dec_valid && (sel != cpu_pkg::FU_NONE) && dest_clear;

	//////////////////////////////
	// dispatch
	//////////////////////////////
	assign ready = waiting & r0 & r1;
	assign start = {ready[2] && !ready[1], ready[1], ready[0]};

	// mem borrows ports 2 and 3 when alu1 is not dispatching
	assign rd_addr[0] = src0_q[0];
	assign rd_addr[1] = src1_q[0];
	assign rd_addr[2] = ready[1] ? src0_q[1] : src0_q[2];
	assign rd_addr[3] = ready[1] ? src1_q[1] : src1_q[2];

	assign start_alu0 = start[0];
	assign op_alu0 = op_q[0];
	assign dest_alu0 = dest_q[0];
	assign operand_a_alu0 = rd_data[0];
	assign operand_b_alu0 = use_imm_q[0] ? imm_q[0] : rd_data[1];

	assign start_alu1 = start[1];
	assign op_alu1 = op_q[1];
	assign dest_alu1 = dest_q[1];
	assign operand_a_alu1 = rd_data[2];
	assign operand_b_alu1 = use_imm_q[1] ? imm_q[1] : rd_data[3];

	// store: base plus offset on a, data register on b
	assign start_mem = start[2];
	assign op_mem = op_q[2];
	assign dest_mem = dest_q[2];
	assign operand_a_mem = (op_q[2] == cpu_pkg::OP_STORE) ? rd_data[2] + imm_q[2] : rd_data[2];
	assign operand_b_mem = use_imm_q[2] ? imm_q[2] : rd_data[3];

	//////////////////////////////
	// writeback grant
	//////////////////////////////
	always_comb begin
		for (int u = 0; u < UNITS; u++) begin
			cand[u] = done[u] && (res_dest[u] != `CPU_NO_DEST);
			// WAR: hold while a waiting unit still has to read this register
			for (int f = 0; f < UNITS; f++) begin
				if (waiting[f] && ((r0[f] && src0_q[f] == res_dest[u]) ||
						(r1[f] && !use_imm_q[f] && src1_q[f] == res_dest[u]))) begin
					cand[u] = 1'b0;
				end
			end
		end
	end

	assign grant = {cand[2] && !cand[1] && !cand[0], cand[1] && !cand[0], cand[0]};
	assign grant_alu0 = grant[0];
	assign grant_alu1 = grant[1];
	assign grant_mem = grant[2];

	always_comb begin
		gnt_unit = cpu_pkg::FU_NONE;
		wb_dest = res_dest[2];
		wb_value = result[2];
		if (grant[0]) begin
			gnt_unit = cpu_pkg::FU_ALU0;
			wb_dest = res_dest[0];
			wb_value = result[0];
		end else if (grant[1]) begin
			gnt_unit = cpu_pkg::FU_ALU1;
			wb_dest = res_dest[1];
			wb_value = result[1];
		end else if (grant[2]) begin
			gnt_unit = cpu_pkg::FU_MEM;
		end
	end

	assign wb_valid = |grant;

	// stores and no-dest results leave without grant
	always_comb begin
		for (int u = 0; u < UNITS; u++) begin
			free[u] = done[u] && (grant[u] || res_dest[u] == `CPU_NO_DEST);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
			waiting <= '0;
			r0 <= '0;
			r1 <= '0;
			for (int r = 0; r < `CPU_REG_COUNT; r++) begin
				reg_unit[r] <= cpu_pkg::FU_NONE;
			end
		end else begin
			waiting <= waiting & ~start;
			for (int u = 0; u < UNITS; u++) begin
				if (free[u]) begin
					busy[u] <= 1'b0;
				end
				if (wb_valid && q0[u] == gnt_unit) begin
					r0[u] <= 1'b1;
				end
				if (wb_valid && q1[u] == gnt_unit) begin
					r1[u] <= 1'b1;
				end
			end
			if (wb_valid) begin
				reg_unit[wb_dest] <= cpu_pkg::FU_NONE;
			end
			if (issue) begin
				busy[sel] <= 1'b1;
				waiting[sel] <= 1'b1;
				r0[sel] <= src_ready(reg_unit[dec_src0]);
				r1[sel] <= dec_use_imm || src_ready(reg_unit[dec_src1]);
				if (dec_dest != `CPU_NO_DEST) begin
					reg_unit[dec_dest] <= sel;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			op_q[sel] <= dec_op;
			dest_q[sel] <= dec_dest;
			src0_q[sel] <= dec_src0;
			src1_q[sel] <= dec_src1;
			q0[sel] <= reg_unit[dec_src0];
			q1[sel] <= dec_use_imm ? cpu_pkg::FU_NONE : reg_unit[dec_src1];
			use_imm_q[sel] <= dec_use_imm;
			imm_q[sel] <= dec_imm;
		end
	end

endmodule

`default_nettype wire

// File: design/scoreboard_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_cpu (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  cpu_pkg::word_t     instr,
	output logic               stall,
	output logic               wb_valid,
	output cpu_pkg::reg_addr_t wb_dest,
	output cpu_pkg::word_t     wb_value
);

	logic               dec_valid;
	cpu_pkg::fu_op_t    dec_op;
	cpu_pkg::reg_addr_t dec_dest;
	cpu_pkg::reg_addr_t dec_src0;
	cpu_pkg::reg_addr_t dec_src1;
	logic               dec_use_imm;
	cpu_pkg::word_t     dec_imm;
	logic               issue;
	cpu_pkg::reg_addr_t rd_addr [0:3];
	cpu_pkg::word_t     rd_data [0:3];

	// unit handshakes, index 0 alu0, 1 alu1, 2 mem
	logic               start [0:2];
	cpu_pkg::fu_op_t    op [0:2];
	cpu_pkg::reg_addr_t dest [0:2];
	cpu_pkg::word_t     operand_a [0:2];
	cpu_pkg::word_t     operand_b [0:2];
	logic               done [0:2];
	cpu_pkg::reg_addr_t res_dest [0:2];
	cpu_pkg::word_t     result [0:2];
	logic               grant [0:2];

	instr_decoder u_decoder (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.issue(issue), .stall(stall), .dec_valid(dec_valid), .dec_op(dec_op),
		.dec_dest(dec_dest), .dec_src0(dec_src0), .dec_src1(dec_src1),
		.dec_use_imm(dec_use_imm), .dec_imm(dec_imm)
	);

	scoreboard u_scoreboard (
		.clk(clk), .rst_n(rst_n), .dec_valid(dec_valid), .dec_op(dec_op),
		.dec_dest(dec_dest), .dec_src0(dec_src0), .dec_src1(dec_src1),
		.dec_use_imm(dec_use_imm), .dec_imm(dec_imm), .issue(issue),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.start_alu0(start[0]), .op_alu0(op[0]), .dest_alu0(dest[0]),
		.operand_a_alu0(operand_a[0]), .operand_b_alu0(operand_b[0]), .done_alu0(done[0]),
		.res_dest_alu0(res_dest[0]), .result_alu0(result[0]), .grant_alu0(grant[0]),
		.start_alu1(start[1]), .op_alu1(op[1]), .dest_alu1(dest[1]),
		.operand_a_alu1(operand_a[1]), .operand_b_alu1(operand_b[1]), .done_alu1(done[1]),
		.res_dest_alu1(res_dest[1]), .result_alu1(result[1]), .grant_alu1(grant[1]),
		.start_mem(start[2]), .op_mem(op[2]), .dest_mem(dest[2]),
		.operand_a_mem(operand_a[2]), .operand_b_mem(operand_b[2]), .done_mem(done[2]),
		.res_dest_mem(res_dest[2]), .result_mem(result[2]), .grant_mem(grant[2]),
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_value(wb_value)
	);

	register_file u_register_file (
		.clk(clk), .rst_n(rst_n), .rd_addr(rd_addr), .rd_data(rd_data),
		.wb_valid(wb_valid), .wb_dest(wb_dest), .wb_value(wb_value)
	);

	alu_unit u_alu0 (
		.clk(clk), .rst_n(rst_n), .start(start[0]), .op(op[0]), .dest(dest[0]),
		.operand_a(operand_a[0]), .operand_b(operand_b[0]), .grant(grant[0]),
		.done(done[0]), .res_dest(res_dest[0]), .result(result[0])
	);

	alu_unit u_alu1 (
		.clk(clk), .rst_n(rst_n), .start(start[1]), .op(op[1]), .dest(dest[1]),
		.operand_a(operand_a[1]), .operand_b(operand_b[1]), .grant(grant[1]),
		.done(done[1]), .res_dest(res_dest[1]), .result(result[1])
	);

	mem_unit u_mem (
		.clk(clk), .rst_n(rst_n), .start(start[2]), .op(op[2]), .dest(dest[2]),
		.operand_a(operand_a[2]), .operand_b(operand_b[2]), .grant(grant[2]),
		.done(done[2]), .res_dest(res_dest[2]), .result(result[2])
	);

endmodule

`default_nettype wire

// File: test/cpu_trace.txt
# I <instr hex>        instruction word, sent in order
# W <reg> <value hex>  expected writeback, appended to that register's queue
# immediates and register forms in dependent chains
I 0105
W 1 0005
I 023D
W 2 0002
I 1347
W 3 FFFB
I 0C61
W 4 0000
I 1D23
W 5 000A
I 16B0
W 6 001A
# back to back adds, repeated writes to r1
I 012F
W 1 0014
I 012F
W 1 0023
I 0201
W 2 0001
I 011F
W 1 FFFF
I 0921
W 1 FFFE
I 0342
W 3 0003
# store then load of the same address
I B504
I A604
W 6 000A
I 04C1
W 4 000B
I B146
I A564
W 5 FFFE
I 1AA2
W 2 FFFD
# unknown opcode and a write to the no-dest register
I F923
I 0723
# later write to r3 while an add that reads r3 waits on a load
I A407
W 4 FFFE
I 0E83
W 6 0001
I 0309
W 3 0009
I 0966
W 1 000A

// File: test/tb_scoreboard_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard_cpu;

	localparam int STALL_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 400;
	localparam int QUIET_CYCLES = 20;

	logic               clk;
	logic               rst_n;
	logic               instr_valid;
	cpu_pkg::word_t     instr;
	logic               stall;
	logic               wb_valid;
	cpu_pkg::reg_addr_t wb_dest;
	cpu_pkg::word_t     wb_value;

	// instruction words in program order
	cpu_pkg::word_t     program_q [$];
	// expected writebacks in program order and looked up per register
	cpu_pkg::reg_addr_t expect_reg [$];
	cpu_pkg::word_t     expect_val [$];
	logic [31:0]        lcg_state;
	logic               started;
	logic               rst_seen;

	scoreboard_cpu u_dut (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.stall(stall), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_value(wb_value)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////
	// failure reporting
	//////////////////////////////
	task automatic stop_on_error();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s at %0t", what, $time);
		stop_on_error();
	endtask

	task automatic check_low(input string name, input logic actual);
		if (actual !== 1'b0) begin
			$display("error at %0t: %s got %b expected 0", $time, name, actual);
			stop_on_error();
		end
	endtask

	// oldest expected entry for one register or -1
	function automatic int find_expected(input cpu_pkg::reg_addr_t dest);
		for (int i = 0; i < expect_reg.size(); i++) begin
			if (expect_reg[i] == dest) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic check_wb_dest(input cpu_pkg::reg_addr_t dest);
		if (find_expected(dest) < 0) begin
			report_failure($sformatf("unexpected writeback to register %0d", dest));
		end
	endtask

	task automatic check_wb_value(input cpu_pkg::reg_addr_t dest, input cpu_pkg::word_t value);
		int idx;
		idx = find_expected(dest);
		if (value !== expect_val[idx]) begin
			$display("error at %0t: wb_value got %h expected %h (register %0d)",
				$time, value, expect_val[idx], dest);
			stop_on_error();
		end
		expect_reg.delete(idx);
		expect_val.delete(idx);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	//////////////////////////////
	// trace loading
	//////////////////////////////
	task automatic load_trace();
		int fd;
		int reg_num;
		logic [15:0] value;
		logic [8*8-1:0] tag;
		logic [8*120-1:0] line_buf;
		fd = $fopen("test/cpu_trace.txt", "r");
		if (fd == 0) begin
			report_failure("could not open test/cpu_trace.txt");
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				void'($fgets(line_buf, fd));
			end else if (tag == "I") begin
				void'($fscanf(fd, "%h", value));
				program_q.push_back(value);
			end else if (tag == "W") begin
				void'($fscanf(fd, "%d %h", reg_num, value));
				if (reg_num < 0 || reg_num > 6) begin
					report_failure("trace names a register that cannot be written");
				end
				expect_reg.push_back(cpu_pkg::reg_addr_t'(reg_num));
				expect_val.push_back(value);
			end else begin
				report_failure("trace holds a line of unknown kind");
			end
		end
		$fclose(fd);
	endtask

	// one instruction held until the decoder takes it
	task automatic send_instr(input cpu_pkg::word_t word);
		int waited;
		instr_valid <= 1'b1;
		instr <= word;
		started <= 1'b1;
		@(posedge clk);
		waited = 0;
		while (stall) begin
			if (waited == STALL_TIMEOUT) begin
				report_failure("stall stayed high past its timeout");
			end
			waited++;
			@(posedge clk);
		end
	endtask

	// writeback monitor
	always @(posedge clk) begin
		if (rst_seen && !started) begin
			check_low("stall", stall);
			check_low("wb_valid", wb_valid);
		end
		if (rst_n && wb_valid) begin
			check_wb_dest(wb_dest);
			check_wb_value(wb_dest, wb_value);
		end
		if (!rst_n) begin
			rst_seen <= 1'b1;
		end
	end

	initial begin
		int gap;
		int waited;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		started = 1'b0;
		rst_seen = 1'b0;
		lcg_state = 32'd9;
		load_trace();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		foreach (program_q[i]) begin
			send_instr(program_q[i]);
			// 0 to 3 idle cycles
			gap = int'((lcg_next() >> 16) % 4);
			if (gap > 0) begin
				instr_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
		end
		instr_valid <= 1'b0;
		waited = 0;
		while (expect_reg.size() != 0) begin
			if (waited == DRAIN_TIMEOUT) begin
				report_failure($sformatf("%0d writebacks never arrived", expect_reg.size()));
			end
			waited++;
			@(negedge clk);
		end
		// quiet window with no writeback allowed
		repeat (QUIET_CYCLES) @(negedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
